// File: project.f
flit_pkg.sv
mesh_pkg.sv
input_fifo.sv
port_ctrl.sv
credit_counter.sv
switch_alloc.sv
crossbar.sv
mesh_router.sv
tb_mesh_router.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mesh router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_mesh_router -f project.f -o tb_mesh_router
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mesh_router > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

// File: tb_mesh_router.sv
`timescale 1ns/100ps

module tb_mesh_router import flit_pkg::*, mesh_pkg::*; ();

    localparam int B = 4;
    localparam int FW = FLAG_W + FPAY_W;
    localparam int TIMEOUT = 2000;   // cycles per wait
    localparam int HERE_X = 3;
    localparam int HERE_Y = 3;

    typedef logic [FW-1:0] flit_t;

    logic                    clk = 1'b0;
    logic                    reset = 1'b1;
    logic [NUM_PORTS*FW-1:0] flit_in_all = '0;
    logic [NUM_PORTS-1:0]    flit_in_we_all = '0;
    logic [NUM_PORTS-1:0]    credit_out_all;
    logic [NUM_PORTS*FW-1:0] flit_out_all;
    logic [NUM_PORTS-1:0]    flit_out_we_all;
    logic [NUM_PORTS-1:0]    credit_in_all = '0;

    flit_t drv_q [NUM_PORTS][$];             // flits waiting to enter each input
    flit_t exp_q [NUM_PORTS*NUM_PORTS][$];   // indexed input*5 + output
    int    up_credit [NUM_PORTS] = '{default: B};
    int    wr_cnt [NUM_PORTS] = '{default: 0};
    int    cr_cnt [NUM_PORTS] = '{default: 0};
    int    recv_cnt [NUM_PORTS] = '{default: 0};
    int    pending [NUM_PORTS] = '{default: 0};    // credits owed downstream
    int    cur_src [NUM_PORTS] = '{default: -1};   // input whose packet holds the output
    int    dst_x [NUM_PORTS] = '{3, 5, 3, 0, 3};   // one destination per output
    int    dst_y [NUM_PORTS] = '{3, 3, 6, 3, 0};
    logic [NUM_PORTS-1:0] withhold = '0;
    logic [31:0] lcg_state = 32'hbe90;
    int    mismatches = 0;
    int    failures = 0;
    logic  timed_out = 1'b0;

    mesh_router #(.B(B), .Fpay(FPAY_W), .XY_W(COORD_W)) mesh_router_i (
        .clk             (clk),
        .reset           (reset),
        .current_r_addr  ({coord_t'(HERE_Y), coord_t'(HERE_X)}),
        .flit_in_all     (flit_in_all),
        .flit_in_we_all  (flit_in_we_all),
        .credit_out_all  (credit_out_all),
        .flit_out_all    (flit_out_all),
        .flit_out_we_all (flit_out_we_all),
        .credit_in_all   (credit_in_all)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 local, 1 east, 2 north, 3 west, 4 south
    function automatic int xy_port(input int dx, input int dy);
        if (dx != HERE_X) return (dx > HERE_X) ? 1 : 3;
        if (dy != HERE_Y) return (dy > HERE_Y) ? 2 : 4;
        return 0;
    endfunction

    function automatic logic all_empty();
        logic e;
        e = 1'b1;
        for (int i = 0; i < NUM_PORTS; i++) if (drv_q[i].size() != 0) e = 1'b0;
        for (int k = 0; k < NUM_PORTS*NUM_PORTS; k++) if (exp_q[k].size() != 0) e = 1'b0;
        return e;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("%s", msg);
    endtask

    task automatic send_packet(input int src, input int dx, input int dy, input int len);
        flit_t f;
        int    port;
        port = xy_port(dx, dy);
        for (int n = 0; n < len; n++) begin
            lcg_state = lcg_next(lcg_state);
            f[FPAY_W-1:0] = lcg_state;
            if (n == 0) begin
                f[DST_X_LSB +: COORD_W] = coord_t'(dx);
                f[DST_Y_LSB +: COORD_W] = coord_t'(dy);
            end
            f[FW-1 -: FLAG_W] = {n == 0, n == len - 1};   // head, tail
            drv_q[src].push_back(f);
            exp_q[src*NUM_PORTS + port].push_back(f);
        end
    endtask

    // packet on an output must be contiguous and in order
    task automatic receive_flit(input int o, input flit_t f);
        int src;
        recv_cnt[o]++;
        src = cur_src[o];
        if (src < 0) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (exp_q[i*NUM_PORTS + o].size() > 0 && exp_q[i*NUM_PORTS + o][0] == f) src = i;
            end
        end
        if (src < 0) begin
            report_failure($sformatf("output %0d delivered a flit no input sent there", o));
        end else if (exp_q[src*NUM_PORTS + o].size() == 0) begin
            report_failure($sformatf("output %0d delivered an extra flit", o));
        end else begin
            check($sformatf("flit_out_all[%0d]", o), 64'(f),
                  64'(exp_q[src*NUM_PORTS + o].pop_front()));
            cur_src[o] = f[FPAY_W + TAIL_BIT] ? -1 : src;
        end
    endtask

    // upstream sender and downstream receiver models
    always @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (credit_out_all[i]) begin
                    up_credit[i]++;
                    cr_cnt[i]++;
                end
                if (drv_q[i].size() > 0 && up_credit[i] > 0) begin
                    flit_in_all[i*FW +: FW] <= drv_q[i].pop_front();
                    flit_in_we_all[i] <= 1'b1;
                    up_credit[i]--;
                    wr_cnt[i]++;
                end else begin
                    flit_in_we_all[i] <= 1'b0;
                end
            end
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (flit_out_we_all[o]) receive_flit(o, flit_out_all[o*FW +: FW]);
                pending[o] += int'(flit_out_we_all[o]);
                if (!withhold[o] && pending[o] > 0) begin
                    credit_in_all[o] <= 1'b1;   // one slot freed per cycle
                    pending[o]--;
                end else begin
                    credit_in_all[o] <= 1'b0;
                end
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_drained(input string what);
        int cycles;
        cycles = 0;
        while (!all_empty() && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                timed_out = 1'b1;
                report_failure($sformatf("timeout while %s", what));
            end
        end
        idle(5);
    endtask

    task automatic wait_received(input int o, input int target);
        int cycles;
        cycles = 0;
        while (recv_cnt[o] < target && !timed_out) begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                timed_out = 1'b1;
                report_failure($sformatf("timeout waiting for flits on output %0d", o));
            end
        end
    endtask

    task automatic depth_after_reset();
        int base [NUM_PORTS];
        for (int n = 0; n < 8; n++) begin
            @(posedge clk);
            check("flit_out_we_all", 64'(flit_out_we_all), 64'(0));
            check("credit_out_all", 64'(credit_out_all), 64'(0));
        end
        withhold = '1;
        for (int o = 0; o < NUM_PORTS; o++) begin
            base[o] = recv_cnt[o];
            for (int n = 0; n < B + 2; n++) begin
                send_packet((o + 1) % NUM_PORTS, dst_x[o], dst_y[o], 1);
            end
        end
        for (int o = 0; o < NUM_PORTS; o++) wait_received(o, base[o] + B);
        idle(20);
        for (int o = 0; o < NUM_PORTS; o++) begin
            check($sformatf("recv_cnt[%0d]", o), 64'(recv_cnt[o] - base[o]), 64'(B));
        end
        withhold = '0;
        wait_drained("draining after the depth test");
    endtask

    task automatic xy_routing();
        for (int i = 0; i < NUM_PORTS; i++) begin
            for (int d = 0; d < NUM_PORTS; d++) send_packet(i, dst_x[d], dst_y[d], 1);
        end
        send_packet(2, 4, 0, 1);   // x wins over y
        send_packet(4, 1, 7, 1);
        wait_drained("routing single-flit packets");
    endtask

    task automatic long_packet();
        send_packet(1, 3, 6, 8);
        wait_drained("sending a long packet north");
    endtask

    task automatic shared_output();
        send_packet(0, 3, 1, 6);   // all go south
        send_packet(2, 3, 0, 6);
        send_packet(4, 3, 2, 3);
        wait_drained("inputs sharing the south output");
    endtask

    task automatic backpressure();
        int base;
        base = recv_cnt[1];
        withhold[1] = 1'b1;
        send_packet(0, 6, 3, B + 4);
        wait_received(1, base + B);
        idle(20);
        check("recv_cnt[1] stalled", 64'(recv_cnt[1] - base), 64'(B));
        withhold[1] = 1'b0;
        wait_drained("resuming after credits returned");
        check("recv_cnt[1] resumed", 64'(recv_cnt[1] - base), 64'(B + 4));
    endtask

    task automatic credit_balance();
        idle(5);
        for (int i = 0; i < NUM_PORTS; i++) begin
            check($sformatf("credit_out_all[%0d] count", i), 64'(cr_cnt[i]), 64'(wr_cnt[i]));
        end
    endtask

    initial begin
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        if (!timed_out) depth_after_reset();
        if (!timed_out) xy_routing();
        if (!timed_out) long_packet();
        if (!timed_out) shared_output();
        if (!timed_out) backpressure();
        if (!timed_out) credit_balance();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: mesh_router.sv
`timescale 1ns/100ps

module mesh_router import flit_pkg::*, mesh_pkg::*; #(
    parameter int B = 4,
    parameter int Fpay = FPAY_W,
    parameter int XY_W = COORD_W,
    localparam int FW = FLAG_W + Fpay
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [2*XY_W-1:0]       current_r_addr,   // {y, x}
    input  logic [NUM_PORTS*FW-1:0] flit_in_all,
    input  logic [NUM_PORTS-1:0]    flit_in_we_all,
    output logic [NUM_PORTS-1:0]    credit_out_all,
    output logic [NUM_PORTS*FW-1:0] flit_out_all,
    output logic [NUM_PORTS-1:0]    flit_out_we_all,
    input  logic [NUM_PORTS-1:0]    credit_in_all
);

    coord_t               cur_x;
    coord_t               cur_y;
    logic [FW-1:0]        front_flit [NUM_PORTS];
    logic [NUM_PORTS-1:0] not_empty;
    logic [NUM_PORTS-1:0] req;
    logic [NUM_PORTS-1:0] hold;
    port_mask_t           dest [NUM_PORTS];
    port_mask_t           grant;
    port_mask_t           has_credit;
    port_mask_t           out_sel [NUM_PORTS];
    port_mask_t           out_valid;

    assign cur_x = coord_t'(current_r_addr[XY_W-1:0]);
    assign cur_y = coord_t'(current_r_addr[2*XY_W-1:XY_W]);

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        input_fifo #(.B(B), .Fpay(Fpay)) fifo_i (
            .clk        (clk),
            .reset      (reset),
            .wr_flit    (flit_in_all[i*FW +: FW]),
            .wr_en      (flit_in_we_all[i]),
            .rd_en      (grant[i]),
            .front_flit (front_flit[i]),
            .not_empty  (not_empty[i]),
            .credit_out (credit_out_all[i])
        );

        port_ctrl #(.Fpay(Fpay), .XY_W(XY_W)) ctrl_i (
            .clk        (clk),
            .reset      (reset),
            .current_x  (cur_x),
            .current_y  (cur_y),
            .front_flit (front_flit[i]),
            .not_empty  (not_empty[i]),
            .granted    (grant[i]),
            .req        (req[i]),
            .hold       (hold[i]),
            .dest       (dest[i])
        );

        // indexed by output port
        credit_counter #(.B(B)) credit_i (
            .clk        (clk),
            .reset      (reset),
            .sent       (out_valid[i]),
            .credit_in  (credit_in_all[i]),
            .has_credit (has_credit[i])
        );
    end

    switch_alloc alloc_i (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .hold       (hold),
        .dest       (dest),
        .has_credit (has_credit),
        .grant      (grant),
        .out_sel    (out_sel),
        .out_valid  (out_valid)
    );

    crossbar #(.Fpay(Fpay)) xbar_i (
        .clk             (clk),
        .reset           (reset),
        .in_flits        (front_flit),
        .out_sel         (out_sel),
        .out_valid       (out_valid),
        .flit_out_all    (flit_out_all),
        .flit_out_we_all (flit_out_we_all)
    );

endmodule

// File: crossbar.sv
`timescale 1ns/100ps

module crossbar import flit_pkg::*, mesh_pkg::*; #(
    parameter int Fpay = FPAY_W,
    localparam int FW = FLAG_W + Fpay
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [FW-1:0]           in_flits [NUM_PORTS],
    input  port_mask_t              out_sel [NUM_PORTS],
    input  port_mask_t              out_valid,
    output logic [NUM_PORTS*FW-1:0] flit_out_all,
    output logic [NUM_PORTS-1:0]    flit_out_we_all
);

    logic [FW-1:0] sel_flit [NUM_PORTS];

    // one-hot and-or mux per output
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            sel_flit[o] = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (out_sel[o][i]) sel_flit[o] = sel_flit[o] | in_flits[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (out_valid[o]) flit_out_all[o*FW +: FW] <= sel_flit[o];   // holds when idle
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_out_we_all <= '0;
        end else begin
            flit_out_we_all <= out_valid;
        end
    end

endmodule

// File: switch_alloc.sv
`timescale 1ns/100ps

module switch_alloc import mesh_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_PORTS-1:0] req,
    input  logic [NUM_PORTS-1:0] hold,
    input  port_mask_t           dest [NUM_PORTS],
    input  port_mask_t           has_credit,
    output port_mask_t           grant,
    output port_mask_t           out_sel [NUM_PORTS],
    output port_mask_t           out_valid
);

    port_mask_t        cand [NUM_PORTS];        // inputs asking for each output
    port_mask_t        owner_q [NUM_PORTS];     // input holding each output
    port_mask_t        grant_col [NUM_PORTS];   // outputs granting each input
    port_mask_t        locked;
    logic [PORT_W-1:0] ptr_q [NUM_PORTS];

    // first candidate at or after ptr
    function automatic port_mask_t rr_pick(input port_mask_t c, input logic [PORT_W-1:0] ptr);
        port_mask_t pick;
        int         idx;
        pick = '0;
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % NUM_PORTS;
            if (c[idx]) begin
                pick = '0;
                pick[idx] = 1'b1;
            end
        end
        return pick;
    endfunction

    function automatic logic [PORT_W-1:0] next_ptr(input port_mask_t winner);
        logic [PORT_W-1:0] n;
        n = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (winner[i]) n = (i == NUM_PORTS - 1) ? '0 : PORT_W'(i + 1);
        end
        return n;
    endfunction

    always_comb begin
        grant = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                cand[o][i] = req[i] & dest[i][o];
            end
            locked[o] = |(owner_q[o] & hold);   // lock lasts while the owner's packet runs
            if (!has_credit[o]) begin
                out_sel[o] = '0;
            end else if (locked[o]) begin
                out_sel[o] = owner_q[o] & cand[o];
            end else begin
                out_sel[o] = rr_pick(cand[o], ptr_q[o]);
            end
            out_valid[o] = |out_sel[o];
            grant = grant | out_sel[o];
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                grant_col[i][o] = out_sel[o][i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                owner_q[o] <= '0;
                ptr_q[o]   <= '0;
            end
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (out_valid[o]) begin
                    owner_q[o] <= out_sel[o];
                    if (!locked[o]) ptr_q[o] <= next_ptr(out_sel[o]);   // new packet won
                end else if (!locked[o]) begin
                    owner_q[o] <= '0;   // drop a stale owner
                end
            end
        end
    end

    // input routes are one-hot, so an input never wins twice
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_chk
        a_one_output: assert property (@(posedge clk) disable iff (reset) $onehot0(grant_col[i]))
            else $error("input %0d granted by more than one output", i);
    end

endmodule

// File: credit_counter.sv
`timescale 1ns/100ps

module credit_counter #(
    parameter int B = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic sent,
    input  logic credit_in,
    output logic has_credit
);

    localparam int CNT_W = $clog2(B + 1);

    logic [CNT_W-1:0] count;   // free slots downstream

    assign has_credit = (count != '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= CNT_W'(B);   // downstream buffer starts empty
        end else begin
            case ({sent, credit_in})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // downstream returns no more credits than it has slots
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (credit_in && !sent) |-> (count < CNT_W'(B)))
        else $error("credit returned past the buffer depth");

    // allocator only sends into a free slot
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        sent |-> (count != '0))
        else $error("flit sent without a credit");

endmodule

// File: port_ctrl.sv
`timescale 1ns/100ps

module port_ctrl import flit_pkg::*, mesh_pkg::*; #(
    parameter int Fpay = FPAY_W,
    parameter int XY_W = COORD_W,
    localparam int FW = FLAG_W + Fpay
) (
    input  logic          clk,
    input  logic          reset,
    input  coord_t        current_x,
    input  coord_t        current_y,
    input  logic [FW-1:0] front_flit,
    input  logic          not_empty,
    input  logic          granted,
    output logic          req,
    output logic          hold,
    output port_mask_t    dest
);

    port_state_t state;
    port_mask_t  route_q;      // output held for the body flits
    port_mask_t  route_calc;
    port_id_t    route_port;
    flit_kind_t  kind;
    coord_t      dst_x;
    coord_t      dst_y;
    logic        is_head;
    logic        is_tail;

    // coordinate fields must fit the head flit layout
    if (XY_W != $bits(coord_t) || DST_Y_LSB - DST_X_LSB < XY_W) begin : g_bad_xy
        $error("coordinate width does not match the head flit fields");
    end

    assign kind    = front_flit[FW-1 -: FLAG_W];
    assign is_head = kind[HEAD_BIT];
    assign is_tail = kind[TAIL_BIT];
    assign dst_x   = coord_t'(front_flit[DST_X_LSB +: XY_W]);
    assign dst_y   = coord_t'(front_flit[DST_Y_LSB +: XY_W]);

    // XY order, x first
    always_comb begin
        if (dst_x > current_x) begin
            route_port = port_east;
        end else if (dst_x < current_x) begin
            route_port = port_west;
        end else if (dst_y > current_y) begin
            route_port = port_north;
        end else if (dst_y < current_y) begin
            route_port = port_south;
        end else begin
            route_port = port_local;
        end
    end

    assign route_calc = port_mask_t'(1) << route_port;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:
                    if (not_empty && is_head && granted && !is_tail) state <= st_active;
                st_active:
                    if (granted && is_tail) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && granted) route_q <= route_calc;
    end

    assign req  = not_empty;
    assign hold = (state == st_active);   // body flits still to come
    assign dest = (state == st_active) ? route_q : route_calc;

    // a packet must start with a head flit
    a_head_first: assert property (@(posedge clk) disable iff (reset)
        (state == st_idle && not_empty) |-> is_head)
        else $error("body flit at the front of an idle input");

endmodule

// File: input_fifo.sv
`timescale 1ns/100ps

module input_fifo import flit_pkg::*; #(
    parameter int B = 4,
    parameter int Fpay = FPAY_W,
    localparam int FW = FLAG_W + Fpay
) (
    input  logic          clk,
    input  logic          reset,
    input  logic [FW-1:0] wr_flit,
    input  logic          wr_en,
    input  logic          rd_en,
    output logic [FW-1:0] front_flit,
    output logic          not_empty,
    output logic          credit_out
);

    localparam int PTR_W = (B > 1) ? $clog2(B) : 1;
    localparam int CNT_W = $clog2(B + 1);

    logic [FW-1:0]    mem [B];
    logic [FW-1:0]    in_flit_q;   // incoming flit, stored one edge later
    logic             in_we_q;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;
    logic             full;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(B - 1)) ? '0 : p + 1'b1;
    endfunction

    assign not_empty  = (count != '0);
    assign full       = (count == CNT_W'(B));
    assign pop        = rd_en && not_empty;
    assign credit_out = pop;   // one credit back per flit leaving
    assign front_flit = mem[rd_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_we_q <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end else begin
            in_we_q <= wr_en;
            if (in_we_q) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            case ({in_we_q, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) in_flit_q <= wr_flit;
        if (in_we_q) mem[wr_ptr] <= in_flit_q;
    end

    // upstream holds at most B credits, so storage never overflows
    a_no_overflow: assert property (@(posedge clk) disable iff (reset) in_we_q |-> !full)
        else $error("flit written into a full input buffer");

endmodule

// File: mesh_pkg.sv
package mesh_pkg;

    localparam int NUM_PORTS = 5;   // local plus four neighbors
    localparam int PORT_W = $clog2(NUM_PORTS);

    // coordinate width, also the top level default
    localparam int COORD_W = 3;

    typedef enum logic [PORT_W-1:0] {
        port_local = 0,
        port_east  = 1,
        port_north = 2,   // towards larger y
        port_west  = 3,
        port_south = 4
    } port_id_t;

    typedef logic [NUM_PORTS-1:0] port_mask_t;   // one bit per port
    typedef logic [COORD_W-1:0] coord_t;

    // input side packet state
    typedef enum logic {
        st_idle,
        st_active
    } port_state_t;

endpackage

// File: flit_pkg.sv
package flit_pkg;

    // default payload width, the top level passes its own down
    localparam int FPAY_W = 32;

    // head and tail flags sit above the payload
    localparam int FLAG_W = 2;

    typedef logic [FLAG_W-1:0] flit_kind_t;   // {head, tail}, both set for a one-flit packet

    localparam int HEAD_BIT = 1;
    localparam int TAIL_BIT = 0;

    // destination coordinates in a head flit payload
    localparam int DST_X_LSB = 0;
    localparam int DST_Y_LSB = 3;   // right above a 3-bit x field

endpackage
